// ==== Bender.yml ====
package:
  name: cnn_bus_ctrl

sources:
  - files:
      - hw/cnn_ctrl_pkg.sv
      - hw/param_loader.sv
      - hw/host_reg_decode.sv
      - hw/cnn_bus_ctrl.sv
  - target: simulation
    files:
      - dv/cnn_bus_ctrl_chk.sv
      - dv/cnn_bus_ctrl_tb.sv

// ==== dv/cnn_bus_ctrl_chk.sv ====
module cnn_bus_ctrl_chk
(
	input logic                                  clk,
	input logic                                  rst,
	input logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   awaddr,
	input logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   araddr,
	input logic [cnn_ctrl_pkg::BUS_DATA_W-1:0]   wdata,
	input logic                                  wvalid,
	input logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_value,
	input logic                                  weight_mem_wr,
	input logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   weight_mem_addr,
	input logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   weight_mem_data,
	input logic                                  bias_mem_wr,
	input logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   bias_mem_addr,
	input logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   bias_mem_data,
	input logic                                  weight_done,
	input logic                                  bias_done,
	input logic                                  image_set_wr,
	input logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_data,
	input logic                                  irq_clear_wr,
	input logic                                  result_rd,
	input logic                                  params_ready
);

	import cnn_ctrl_pkg::*;

	// Failure tally, sampled by the testbench
	int fail_cnt = 0;

	// Reference word counts, they stop at the totals
	logic [MEM_DATA_W-1:0] w_cnt;
	logic [MEM_DATA_W-1:0] b_cnt;
	// Total seen one edge earlier, i.e. expected done
	logic w_full_q;
	logic b_full_q;
	logic [3:0] nib;
	logic w_take;
	logic b_take;
	logic [32:0] w_exp;
	logic [32:0] b_exp;
	logic [4:0] dec_exp;

	assign nib    = awaddr[BUS_ADDR_W-1 -: 4];
	assign w_take = wvalid && (nib == REGION_WEIGHT) && (w_cnt < LAYER1_WEIGHT_NUM);
	assign b_take = wvalid && (nib == REGION_BIAS) && (b_cnt < LAYER1_BIAS_NUM);

	// Expected memory ports, zero when idle
	assign w_exp = {w_take, w_take ? w_cnt : 16'h0, w_take ? wdata[15:0] : 16'h0};
	assign b_exp = {b_take, b_take ? b_cnt : 16'h0, b_take ? wdata[15:0] : 16'h0};

	// Expected register strobes and data
	assign dec_exp = {(nib == REGION_IMAGE_SET) || (image_set_value != 2'b00),
		(nib == REGION_IMAGE_SET) ? wdata[1:0] : 2'b00,
		nib == REGION_IRQ,
		araddr == {BUS_ADDR_W{1'b1}}};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			w_cnt    <= '0;
			b_cnt    <= '0;
			w_full_q <= 1'b0;
			b_full_q <= 1'b0;
		end
		else
		begin
			w_cnt    <= w_cnt + w_take;
			b_cnt    <= b_cnt + b_take;
			w_full_q <= (w_cnt == LAYER1_WEIGHT_NUM);
			b_full_q <= (b_cnt == LAYER1_BIAS_NUM);
		end
	end

	// Everything quiet one edge after each reset cycle
	// Last one lands on the first cycle out of reset
	a_reset_idle: assert property (@(posedge clk) rst |=> !(weight_mem_wr || bias_mem_wr ||
		weight_done || bias_done || params_ready || image_set_wr || irq_clear_wr || result_rd))
	else
	begin
		fail_cnt++;
		$error("Fail reset_idle: expected %b, got %b", 8'b0000_0000,
			$sampled({weight_mem_wr, bias_mem_wr, weight_done, bias_done, params_ready,
			image_set_wr, irq_clear_wr, result_rd}));
	end

	a_weight_port: assert property (@(posedge clk) disable iff (rst)
		{weight_mem_wr, weight_mem_addr, weight_mem_data} == w_exp)
	else
	begin
		fail_cnt++;
		$error("Fail weight_port: expected %h, got %h", $sampled(w_exp),
			$sampled({weight_mem_wr, weight_mem_addr, weight_mem_data}));
	end

	a_bias_port: assert property (@(posedge clk) disable iff (rst)
		{bias_mem_wr, bias_mem_addr, bias_mem_data} == b_exp)
	else
	begin
		fail_cnt++;
		$error("Fail bias_port: expected %h, got %h", $sampled(b_exp),
			$sampled({bias_mem_wr, bias_mem_addr, bias_mem_data}));
	end

	// Done two edges after the last write, sticky, ready is the AND
	a_done_flags: assert property (@(posedge clk) disable iff (rst)
		{weight_done, bias_done, params_ready} == {w_full_q, b_full_q, w_full_q && b_full_q})
	else
	begin
		fail_cnt++;
		$error("Fail done_flags: expected %b, got %b",
			$sampled({w_full_q, b_full_q, w_full_q && b_full_q}),
			$sampled({weight_done, bias_done, params_ready}));
	end

	a_reg_decode: assert property (@(posedge clk)
		{image_set_wr, image_set_data, irq_clear_wr, result_rd} == dec_exp)
	else
	begin
		fail_cnt++;
		$error("Fail reg_decode: expected %b, got %b", $sampled(dec_exp),
			$sampled({image_set_wr, image_set_data, irq_clear_wr, result_rd}));
	end

endmodule

// ==== dv/cnn_bus_ctrl_tb.sv ====
module cnn_bus_ctrl_tb;

	import cnn_ctrl_pkg::*;

	// Half clock period, limit on done waits
	localparam int CLK_HALF     = 10;
	localparam int DONE_TIMEOUT = 64;

	logic                  clk;
	logic                  rst;
	logic [BUS_ADDR_W-1:0] awaddr;
	logic [BUS_ADDR_W-1:0] araddr;
	logic [BUS_DATA_W-1:0] wdata;
	logic                  wvalid;
	logic [IMG_SET_W-1:0]  image_set_value;
	logic                  weight_mem_wr;
	logic [MEM_DATA_W-1:0] weight_mem_addr;
	logic [MEM_DATA_W-1:0] weight_mem_data;
	logic                  bias_mem_wr;
	logic [MEM_DATA_W-1:0] bias_mem_addr;
	logic [MEM_DATA_W-1:0] bias_mem_data;
	logic                  weight_done;
	logic                  bias_done;
	logic                  image_set_wr;
	logic [IMG_SET_W-1:0]  image_set_data;
	logic                  irq_clear_wr;
	logic                  result_rd;
	logic                  params_ready;

	int seed;
	int tests_run;
	int tests_failed;
	// Checker tally at test start
	int err_mark;
	int wait_fails;
	int weights_sent;

	bind cnn_bus_ctrl cnn_bus_ctrl_chk u_chk (.*);

	cnn_bus_ctrl cnn_bus_ctrl_i (.*);

	always #(CLK_HALF) clk = ~clk;

	// One bus cycle, random low address bits and data
	task automatic drive_bus(input logic [3:0] region, input logic valid);
		@(posedge clk);
		awaddr <= {region, 28'($random(seed))};
		wdata  <= $random(seed);
		wvalid <= valid;
	endtask

	// Poll between edges so done is settled
	task automatic wait_done(input logic for_bias);
		int n;
		n = 0;
		@(negedge clk);
		while (!(for_bias ? bias_done : weight_done) && n < DONE_TIMEOUT)
		begin
			@(negedge clk);
			n++;
		end
		if (!(for_bias ? bias_done : weight_done))
		begin
			$display("Timeout: %s done flag still low after %0d cycles",
				for_bias ? "bias" : "weight", DONE_TIMEOUT);
			wait_fails++;
		end
	endtask

	task automatic begin_test();
		err_mark   = cnn_bus_ctrl_i.u_chk.fail_cnt;
		wait_fails = 0;
	endtask

	task automatic finish_test(input string name);
		int errs;
		// Let pending checks fire
		repeat (3) @(posedge clk);
		@(negedge clk);
		errs = cnn_bus_ctrl_i.u_chk.fail_cnt - err_mark;
		tests_run++;
		if (errs != 0)
		begin
			tests_failed++;
			$display("Fail %s: expected 0 assertion failures, got %0d", name, errs);
		end
		else if (wait_fails != 0)
		begin
			tests_failed++;
			$display("%s: a done flag never came up in time", name);
		end
		else
		begin
			$display("ok   %s", name);
		end
	endtask

	initial
	begin
		seed            = 32'h68a9e1fd;
		tests_run       = 0;
		tests_failed    = 0;
		err_mark        = 0;
		wait_fails      = 0;
		clk             = 1'b0;
		rst             = 1'b1;
		awaddr          = '0;
		araddr          = '0;
		wdata           = '0;
		wvalid          = 1'b0;
		image_set_value = '0;

		// Reset for three cycles, then quiet bus
		begin_test();
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		repeat (2) drive_bus(4'h0, 1'b0);
		finish_test("reset");

		// Weights with random gaps, gap keeps the region but drops wvalid
		begin_test();
		weights_sent = 0;
		while (weights_sent < 120)
		begin
			if (($random(seed) & 3) == 0)
			begin
				drive_bus(REGION_WEIGHT, 1'b0);
			end
			drive_bus(REGION_WEIGHT, 1'b1);
			weights_sent++;
		end
		drive_bus(4'h0, 1'b0);
		finish_test("weight_addr");

		// Biases between weights, two past the total
		begin_test();
		for (int i = 0; i < LAYER1_BIAS_NUM + 2; i++)
		begin
			drive_bus(REGION_WEIGHT, 1'b1);
			weights_sent++;
			drive_bus(REGION_BIAS, 1'b1);
		end
		drive_bus(4'h0, 1'b0);
		wait_done(1'b1);
		finish_test("bias_mixed");

		// Remaining weights, then extra words after done
		begin_test();
		while (weights_sent < LAYER1_WEIGHT_NUM)
		begin
			drive_bus(REGION_WEIGHT, 1'b1);
			weights_sent++;
		end
		drive_bus(4'h0, 1'b0);
		wait_done(1'b0);
		repeat (4) drive_bus(REGION_WEIGHT, 1'b1);
		drive_bus(4'h0, 1'b0);
		finish_test("weight_done");

		// Every nibble three times, result address every third cycle
		begin_test();
		for (int i = 0; i < 48; i++)
		begin
			@(posedge clk);
			awaddr          <= {4'(i), 28'($random(seed))};
			araddr          <= (i % 3 == 0) ? '1 : $random(seed);
			wdata           <= $random(seed);
			image_set_value <= 2'($random(seed));
		end
		finish_test("reg_decode");

		$display("Tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0)
		begin
			$display("*** PASSED ***");
		end
		else
		begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== hw/cnn_bus_ctrl.sv ====
module cnn_bus_ctrl
(
	input  logic                                  clk,
	input  logic                                  rst,
	// CPU write and read addresses
	input  logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   awaddr,
	input  logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   araddr,
	// CPU write data and its valid
	input  logic [cnn_ctrl_pkg::BUS_DATA_W-1:0]   wdata,
	input  logic                                  wvalid,
	// Image-set register readback
	input  logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_value,
	// Weight memory write port
	output logic                                  weight_mem_wr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   weight_mem_addr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   weight_mem_data,
	// Bias memory write port
	output logic                                  bias_mem_wr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   bias_mem_addr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   bias_mem_data,
	// Load status
	output logic                                  weight_done,
	output logic                                  bias_done,
	// Register strobes
	output logic                                  image_set_wr,
	output logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_data,
	output logic                                  irq_clear_wr,
	output logic                                  result_rd,
	output logic                                  params_ready
);

	import cnn_ctrl_pkg::*;

	// Weight loader, 216 words on region 8
	param_loader
	#(
		.WORD_NUM (LAYER1_WEIGHT_NUM),
		.REGION   (REGION_WEIGHT)
	)
	u_weight_loader
	(
		.clk      (clk),
		.rst      (rst),
		.awaddr   (awaddr),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.mem_wr   (weight_mem_wr),
		.mem_addr (weight_mem_addr),
		.mem_data (weight_mem_data),
		.done     (weight_done)
	);

	// Bias loader, 8 words on region 9
	// Runs alongside the weight loader on the same bus
	param_loader
	#(
		.WORD_NUM (LAYER1_BIAS_NUM),
		.REGION   (REGION_BIAS)
	)
	u_bias_loader
	(
		.clk      (clk),
		.rst      (rst),
		.awaddr   (awaddr),
		.wdata    (wdata),
		.wvalid   (wvalid),
		.mem_wr   (bias_mem_wr),
		.mem_addr (bias_mem_addr),
		.mem_data (bias_mem_data),
		.done     (bias_done)
	);

	// Register and result decode
	// also merges the two done flags
	host_reg_decode u_reg_decode
	(
		.awaddr          (awaddr),
		.araddr          (araddr),
		.wdata           (wdata),
		.image_set_value (image_set_value),
		.weight_done     (weight_done),
		.bias_done       (bias_done),
		.image_set_wr    (image_set_wr),
		.image_set_data  (image_set_data),
		.irq_clear_wr    (irq_clear_wr),
		.result_rd       (result_rd),
		.params_ready    (params_ready)
	);

endmodule

// ==== hw/cnn_ctrl_pkg.sv ====
package cnn_ctrl_pkg;

	// Bus side of the host window
	// Write address, read address and write data all share the CPU word width
	localparam int BUS_ADDR_W = 32;
	localparam int BUS_DATA_W = 32;

	// Parameter memory word
	// Same width serves as memory address and as loader word counter
	localparam int MEM_DATA_W = 16;

	// Image-set register field, two bits wide
	localparam int IMG_SET_W = 2;

	// Region codes, taken from the top nibble of the write address
	// Nibble values not listed here decode to no region at all
	typedef enum logic [3:0]
	{
		REGION_IMAGE_SET = 4'h1,
		REGION_IRQ       = 4'h2,
		REGION_WEIGHT    = 4'h8,
		REGION_BIAS      = 4'h9
	} region_e;

	// Result readback lives at the very top of the address space
	localparam logic [BUS_ADDR_W-1:0] RESULT_ADDR = '1;

	// Layer 1 parameter totals
	// 216 weights for the first conv layer, one bias per output channel
	localparam logic [MEM_DATA_W-1:0] LAYER1_WEIGHT_NUM = 16'd216;
	localparam logic [MEM_DATA_W-1:0] LAYER1_BIAS_NUM   = 16'd8;

	// Loader FSM states
	// IDLE waits for the first word, STORE counts, FINISH holds done
	typedef enum logic [1:0]
	{
		LOAD_IDLE,
		LOAD_STORE,
		LOAD_FINISH
	} load_state_e;

endpackage

// ==== hw/host_reg_decode.sv ====
module host_reg_decode
(
	// CPU address and data
	input  logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   awaddr,
	input  logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   araddr,
	input  logic [cnn_ctrl_pkg::BUS_DATA_W-1:0]   wdata,
	// Current contents of the image-set register
	input  logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_value,
	// Loader done flags
	input  logic                                  weight_done,
	input  logic                                  bias_done,
	// Image-set register write port
	output logic                                  image_set_wr,
	output logic [cnn_ctrl_pkg::IMG_SET_W-1:0]    image_set_data,
	// Interrupt register clear strobe
	output logic                                  irq_clear_wr,
	// Result readback strobe
	output logic                                  result_rd,
	// Both parameter sets in place
	output logic                                  params_ready
);

	import cnn_ctrl_pkg::*;

	// Region nibble of the write address
	region_e aw_region;

	assign aw_region = region_e'(awaddr[BUS_ADDR_W-1 -: $bits(region_e)]);

	// Image-set register
	// A write to its region loads the low bits of wdata
	// Any other cycle with a nonzero value writes zero back,
	// so a start request lasts a single cycle
	always_comb
	begin
		if (aw_region == REGION_IMAGE_SET)
		begin
			image_set_wr   = 1'b1;
			image_set_data = wdata[IMG_SET_W-1:0];
		end
		else if (image_set_value != '0)
		begin
			image_set_wr   = 1'b1;
			image_set_data = '0;
		end
		else
		begin
			image_set_wr   = 1'b0;
			image_set_data = '0;
		end
	end

	// Interrupt clear, region only, wvalid not looked at
	// Data written is always zero, hence no data port
	assign irq_clear_wr = (aw_region == REGION_IRQ);

	// Result read on the all-ones address
	assign result_rd = (araddr == RESULT_ADDR);

	// Ready once weights and biases are both loaded
	assign params_ready = weight_done && bias_done;

endmodule

// ==== hw/param_loader.sv ====
module param_loader
#(
	// Number of words expected for this memory
	parameter logic [cnn_ctrl_pkg::MEM_DATA_W-1:0] WORD_NUM = cnn_ctrl_pkg::LAYER1_WEIGHT_NUM,
	// Address region this loader answers to
	parameter cnn_ctrl_pkg::region_e REGION = cnn_ctrl_pkg::REGION_WEIGHT
)
(
	input  logic                                  clk,
	input  logic                                  rst,
	// CPU write side
	input  logic [cnn_ctrl_pkg::BUS_ADDR_W-1:0]   awaddr,
	input  logic [cnn_ctrl_pkg::BUS_DATA_W-1:0]   wdata,
	input  logic                                  wvalid,
	// Parameter memory write port
	output logic                                  mem_wr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   mem_addr,
	output logic [cnn_ctrl_pkg::MEM_DATA_W-1:0]   mem_data,
	// Level flag, high once the full set is stored
	output logic                                  done
);

	import cnn_ctrl_pkg::*;

	// FSM state
	load_state_e state;
	load_state_e state_next;

	// Words accepted so far, doubles as next memory address
	logic [MEM_DATA_W-1:0] word_cnt;

	// Region nibble of the current write address
	region_e aw_region;

	logic region_hit;
	logic cnt_full;
	logic accept;
	logic cnt_clear;

	// Top nibble picks the region
	assign aw_region = region_e'(awaddr[BUS_ADDR_W-1 -: $bits(region_e)]);
	assign region_hit = (aw_region == REGION);

	// Count has hit the total, nothing more goes in
	assign cnt_full = (word_cnt == WORD_NUM);

	// Word taken only while still loading
	// FINISH blocks it, and so does a full count still sitting in STORE
	assign accept = wvalid && region_hit && (state != LOAD_FINISH) && !cnt_full;

	// Counter is wiped on the way into FINISH
	assign cnt_clear = (state == LOAD_STORE) && cnt_full;

	// State register
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= LOAD_IDLE;
		end
		else
		begin
			state <= state_next;
		end
	end

	// Next state
	always_comb
	begin
		state_next = state;
		case (state)
			LOAD_IDLE:
			begin
				// First accepted word starts the store phase
				if (accept)
				begin
					state_next = LOAD_STORE;
				end
			end
			LOAD_STORE:
			begin
				// Total seen one cycle after the last write landed
				if (cnt_full)
				begin
					state_next = LOAD_FINISH;
				end
			end
			LOAD_FINISH:
			begin
				// Parked here until reset
				state_next = LOAD_FINISH;
			end
			default:
			begin
				state_next = LOAD_IDLE;
			end
		endcase
	end

	// Word counter
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			word_cnt <= '0;
		end
		else if (cnt_clear)
		begin
			word_cnt <= '0;
		end
		else if (accept)
		begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// Memory write port, straight from the bus in the same cycle
	// Address and data forced to zero when there is no write
	assign mem_wr   = accept;
	assign mem_addr = accept ? word_cnt : '0;
	assign mem_data = accept ? wdata[MEM_DATA_W-1:0] : '0;

	// Done is just the FINISH state
	assign done = (state == LOAD_FINISH);

endmodule

// ==== verilog.f ====
hw/cnn_ctrl_pkg.sv
hw/param_loader.sv
hw/host_reg_decode.sv
hw/cnn_bus_ctrl.sv
dv/cnn_bus_ctrl_chk.sv
dv/cnn_bus_ctrl_tb.sv
